/* rtl/dcache_pkg.sv */
// Data cache shared definitions
`default_nettype none

package dcache_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  localparam int XLEN = 32;  // Data word
  localparam int PLEN = 32;  // Physical address

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [PLEN-1:0]   adr_t;
  typedef logic [XLEN/8-1:0] be_t;

  // --------------------------------------------------------------------------
  // State machines
  // --------------------------------------------------------------------------

  // Response stage
  typedef enum logic [1:0] {
    RESP_IDLE,
    RESP_FILL,     // Block fill after read miss
    RESP_WRITE,    // Write-through to bus
    RESP_RECOVER   // Re-read arrays for held request
  } resp_state_e;

  // Bus controller
  typedef enum logic [1:0] {
    BIU_IDLE,
    BIU_BURST,
    BIU_SINGLE
  } biu_state_e;

endpackage

`default_nettype wire

/* rtl/dcache_if.sv */
// Data cache internal interfaces
`timescale 1ns/1ps
`default_nettype none

// Lookup result from lookup stage to response stage
interface lookup_if #(
  parameter int SETS        = 64,
  parameter int BLOCK_WORDS = 4
);
  import dcache_pkg::*;

  localparam int IDX_W = $clog2(SETS);
  localparam int OFF_W = $clog2(BLOCK_WORDS);
  localparam int TAG_W = PLEN - IDX_W - OFF_W - 2;

  logic             valid;
  logic             hit;
  logic             we;
  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;
  logic [OFF_W-1:0] offs;
  word_t            d;      // Write data
  be_t              be;
  word_t            q;      // Word read at offs

  modport source (output valid, hit, we, idx, tag, offs, d, be, q);
  modport sink   (input  valid, hit, we, idx, tag, offs, d, be, q);
endinterface

// Bus transfer request and beat stream
interface fill_if;
  import dcache_pkg::*;

  logic  req;       // One-cycle start pulse
  logic  we;
  adr_t  adr;
  word_t d;
  be_t   be;
  logic  beat_vld;
  word_t beat_q;
  logic  done;      // Last beat or error
  logic  err;

  modport req_mp (output req, we, adr, d, be, input beat_vld, beat_q, done, err);
  modport bus    (input  req, we, adr, d, be, output beat_vld, beat_q, done, err);
  modport arr    (input  req, we, adr, beat_vld, beat_q, done, err);
endinterface

`default_nettype wire

/* rtl/dcache_setup.sv */
// Data cache address setup stage
`timescale 1ns/1ps
`default_nettype none

module dcache_setup #(
  parameter int SETS        = 64,
  parameter int BLOCK_WORDS = 4
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      stall_i,
  input  wire logic                      req_i,
  input  wire logic                      we_i,
  input  wire dcache_pkg::adr_t          adr_i,
  input  wire dcache_pkg::be_t           be_i,
  input  wire dcache_pkg::word_t         d_i,
  output      logic                      req_o,
  output      logic                      we_o,
  output      dcache_pkg::adr_t          adr_o,
  output      dcache_pkg::be_t           be_o,
  output      dcache_pkg::word_t         d_o,
  output      logic [$clog2(SETS)-1:0]   idx_o
);

  localparam int IDX_W   = $clog2(SETS);
  localparam int IDX_LSB = $clog2(BLOCK_WORDS) + 2;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      req_o <= 1'b0;
    end else if (!stall_i) begin
      req_o <= req_i;
    end
  end

  // Request payload held while stalled
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      we_o  <= we_i;
      adr_o <= adr_i;
      be_o  <= be_i;
      d_o   <= d_i;
    end
  end

  // Held address lets the arrays be re-read during recovery
  assign idx_o = stall_i ? adr_o[IDX_LSB +: IDX_W] : adr_i[IDX_LSB +: IDX_W];

endmodule

`default_nettype wire

/* rtl/dcache_lookup.sv */
// Data cache tag and data lookup
`timescale 1ns/1ps
`default_nettype none

module dcache_lookup #(
  parameter int SETS        = 64,
  parameter int BLOCK_WORDS = 4
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    stall_i,
  input  wire logic                    req_i,
  input  wire logic                    we_i,
  input  wire dcache_pkg::adr_t        adr_i,
  input  wire dcache_pkg::be_t         be_i,
  input  wire dcache_pkg::word_t       d_i,
  input  wire logic [$clog2(SETS)-1:0] rd_idx_i,
  lookup_if.source                     lif,
  fill_if.arr                          fif
);
  import dcache_pkg::*;

  localparam int IDX_W   = $clog2(SETS);
  localparam int OFF_W   = $clog2(BLOCK_WORDS);
  localparam int IDX_LSB = OFF_W + 2;
  localparam int TAG_W   = PLEN - IDX_W - OFF_W - 2;

  // --------------------------------------------------------------------------
  // Arrays
  // --------------------------------------------------------------------------
  logic [SETS-1:0]  valid_r;
  logic [TAG_W-1:0] tag_mem  [SETS];
  word_t            data_mem [SETS][BLOCK_WORDS];

  logic             vld_rd;
  logic [TAG_W-1:0] tag_rd;
  word_t            blk_rd [BLOCK_WORDS];

  logic [OFF_W-1:0] beat_cnt;
  logic [IDX_W-1:0] fill_idx;
  logic [TAG_W-1:0] fill_tag;
  logic             fill_ok;
  logic             wr_hit;
  logic             hit_c;

  assign fill_idx = fif.adr[IDX_LSB +: IDX_W];
  assign fill_tag = fif.adr[PLEN-1 -: TAG_W];
  assign fill_ok  = fif.done && !fif.we && !fif.err;
  assign wr_hit   = fif.done && fif.we && !fif.err && lif.hit;  // lif held during write

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      valid_r  <= '0;
      vld_rd   <= 1'b0;
      beat_cnt <= '0;
    end else begin
      if (fif.done && !fif.we) valid_r[fill_idx] <= !fif.err;  // Error leaves block invalid
      vld_rd <= valid_r[rd_idx_i];
      if (fif.req) begin
        beat_cnt <= '0;
      end else if (fif.beat_vld) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_ok) tag_mem[fill_idx] <= fill_tag;
    tag_rd <= tag_mem[rd_idx_i];
  end

  always_ff @(posedge clk_i) begin
    if (fif.beat_vld) data_mem[fill_idx][beat_cnt] <= fif.beat_q;
    if (wr_hit) begin
      for (int b = 0; b < XLEN/8; b++) begin
        if (lif.be[b]) data_mem[lif.idx][lif.offs][8*b +: 8] <= lif.d[8*b +: 8];
      end
    end
    for (int w = 0; w < BLOCK_WORDS; w++) begin
      blk_rd[w] <= data_mem[rd_idx_i][w];
    end
  end

  // --------------------------------------------------------------------------
  // Compare and result register
  // --------------------------------------------------------------------------
  assign hit_c = vld_rd && (tag_rd == adr_i[PLEN-1 -: TAG_W]);

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      lif.valid <= 1'b0;
    end else if (!stall_i) begin
      lif.valid <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      lif.hit  <= hit_c;
      lif.we   <= we_i;
      lif.idx  <= adr_i[IDX_LSB +: IDX_W];
      lif.tag  <= adr_i[PLEN-1 -: TAG_W];
      lif.offs <= adr_i[2 +: OFF_W];
      lif.d    <= d_i;
      lif.be   <= be_i;
      lif.q    <= blk_rd[adr_i[2 +: OFF_W]];
    end
  end

endmodule

`default_nettype wire

/* rtl/dcache_resp.sv */
// Data cache response stage
`timescale 1ns/1ps
`default_nettype none

module dcache_resp #(
  parameter int BLOCK_WORDS = 4
) (
  input  wire logic         clk_i,
  input  wire logic         rst_ni,
  output      logic         stall_o,
  output      logic         ack_o,
  output      logic         err_o,
  output dcache_pkg::word_t q_o,
  lookup_if.sink            lif,
  fill_if.req_mp            fif
);
  import dcache_pkg::*;

  localparam int OFF_W = $clog2(BLOCK_WORDS);

  resp_state_e      state_q;
  logic             consumed_q;  // Held lookup result already served
  logic             start_q;
  logic [OFF_W-1:0] cnt_q;
  word_t            cap_q;       // Requested word from beat stream

  logic eval;
  logic rd_hit;
  logic miss_go;
  logic busy;
  logic beat_hit;

  // --------------------------------------------------------------------------
  // Decisions on the lookup result
  // --------------------------------------------------------------------------
  assign eval     = lif.valid && !consumed_q && (state_q == RESP_IDLE);
  assign rd_hit   = eval && !lif.we && lif.hit;
  assign miss_go  = eval && (lif.we || !lif.hit);   // Read miss or any write
  assign busy     = (state_q == RESP_FILL) || (state_q == RESP_WRITE);
  assign beat_hit = fif.beat_vld && (cnt_q == lif.offs);

  assign stall_o = (state_q != RESP_IDLE) || miss_go;
  assign ack_o   = rd_hit || (busy && fif.done && !fif.err);
  assign err_o   = busy && fif.done && fif.err;

  always_comb begin
    if (state_q == RESP_FILL) begin
      q_o = beat_hit ? fif.beat_q : cap_q;  // Word may arrive with the last beat
    end else begin
      q_o = lif.q;
    end
  end

  // Held lookup result keeps the transfer request stable under stall
  assign fif.req = start_q;
  assign fif.we  = lif.we;
  assign fif.adr = {lif.tag, lif.idx, lif.offs, 2'b00};
  assign fif.d   = lif.d;
  assign fif.be  = lif.be;

  // --------------------------------------------------------------------------
  // Miss and write FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RESP_IDLE;
      consumed_q <= 1'b0;
      start_q    <= 1'b0;
      cnt_q      <= '0;
    end else begin
      start_q <= miss_go;

      if (miss_go) begin
        consumed_q <= 1'b1;
      end else if (!stall_o) begin
        consumed_q <= 1'b0;  // Lookup stage advances
      end

      if (start_q) begin
        cnt_q <= '0;
      end else if (fif.beat_vld) begin
        cnt_q <= cnt_q + 1'b1;
      end

      case (state_q)
        RESP_IDLE: begin
          if (miss_go) state_q <= lif.we ? RESP_WRITE : RESP_FILL;
        end
        RESP_FILL,
        RESP_WRITE: begin
          if (fif.done) state_q <= RESP_RECOVER;
        end
        RESP_RECOVER: state_q <= RESP_IDLE;  // Arrays re-read for setup stage
        default: state_q <= RESP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_hit) cap_q <= fif.beat_q;
  end

endmodule

`default_nettype wire

/* rtl/dcache_biu_ctrl.sv */
// Data cache bus controller
`timescale 1ns/1ps
`default_nettype none

module dcache_biu_ctrl #(
  parameter int BLOCK_WORDS = 4
) (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  output      logic                           biu_stb_o,
  input  wire logic                           biu_stb_ack_i,
  output      dcache_pkg::adr_t               biu_adri_o,
  output      logic                           biu_we_o,
  output      dcache_pkg::be_t                biu_be_o,
  output      dcache_pkg::word_t              biu_d_o,
  output      logic [$clog2(BLOCK_WORDS):0]   biu_len_o,
  input  wire dcache_pkg::word_t              biu_q_i,
  input  wire logic                           biu_ack_i,
  input  wire logic                           biu_err_i,
  fill_if.bus                                 fif
);
  import dcache_pkg::*;

  localparam int OFF_W = $clog2(BLOCK_WORDS);
  localparam int LEN_W = OFF_W + 1;

  biu_state_e       state_q;
  logic [OFF_W-1:0] cnt_q;
  logic             last;

  assign last = (cnt_q == OFF_W'(BLOCK_WORDS - 1));

  // --------------------------------------------------------------------------
  // Beat forwarding
  // --------------------------------------------------------------------------
  assign fif.beat_vld = (state_q == BIU_BURST) && biu_ack_i && !biu_err_i;
  assign fif.beat_q   = biu_q_i;
  assign fif.err      = (state_q != BIU_IDLE) && biu_err_i;
  assign fif.done     = ((state_q == BIU_BURST)  && (biu_err_i || (biu_ack_i && last))) ||
                        ((state_q == BIU_SINGLE) && (biu_err_i || biu_ack_i));

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= BIU_IDLE;
      biu_stb_o <= 1'b0;
      cnt_q     <= '0;
    end else begin
      if (biu_stb_ack_i) biu_stb_o <= 1'b0;  // One request outstanding

      case (state_q)
        BIU_IDLE: begin
          if (fif.req) begin
            biu_stb_o <= 1'b1;
            cnt_q     <= '0;
            state_q   <= fif.we ? BIU_SINGLE : BIU_BURST;
          end
        end
        BIU_BURST: begin
          if (biu_err_i) begin
            biu_stb_o <= 1'b0;  // Error ends the burst early
            state_q   <= BIU_IDLE;
          end else if (biu_ack_i) begin
            cnt_q <= cnt_q + 1'b1;
            if (last) state_q <= BIU_IDLE;
          end
        end
        BIU_SINGLE: begin
          if (biu_ack_i || biu_err_i) begin
            biu_stb_o <= 1'b0;
            state_q   <= BIU_IDLE;
          end
        end
        default: state_q <= BIU_IDLE;
      endcase
    end
  end

  // Request payload
  always_ff @(posedge clk_i) begin
    if ((state_q == BIU_IDLE) && fif.req) begin
      biu_we_o <= fif.we;
      biu_d_o  <= fif.d;
      if (fif.we) begin
        biu_adri_o <= fif.adr;
        biu_be_o   <= fif.be;
        biu_len_o  <= LEN_W'(1);
      end else begin
        biu_adri_o <= {fif.adr[PLEN-1:OFF_W+2], {(OFF_W+2){1'b0}}};  // Block aligned
        biu_be_o   <= '1;
        biu_len_o  <= LEN_W'(BLOCK_WORDS);
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/dcache_top.sv */
// Data cache top level
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
  parameter int SETS        = 64,
  parameter int BLOCK_WORDS = 4
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  output      logic                         stall_o,

  // CPU side
  input  wire logic                         mem_req_i,
  input  wire logic                         mem_we_i,
  input  wire dcache_pkg::adr_t             mem_adr_i,
  input  wire dcache_pkg::be_t              mem_be_i,
  input  wire dcache_pkg::word_t            mem_d_i,
  output      logic                         mem_ack_o,
  output      logic                         mem_err_o,
  output      dcache_pkg::word_t            mem_q_o,

  // Bus side
  output      logic                         biu_stb_o,
  input  wire logic                         biu_stb_ack_i,
  output      dcache_pkg::adr_t             biu_adri_o,
  output      logic                         biu_we_o,
  output      dcache_pkg::be_t              biu_be_o,
  output      dcache_pkg::word_t            biu_d_o,
  output      logic [$clog2(BLOCK_WORDS):0] biu_len_o,
  input  wire dcache_pkg::word_t            biu_q_i,
  input  wire logic                         biu_ack_i,
  input  wire logic                         biu_err_i
);
  import dcache_pkg::*;

  logic                    setup_req;
  logic                    setup_we;
  adr_t                    setup_adr;
  be_t                     setup_be;
  word_t                   setup_d;
  logic [$clog2(SETS)-1:0] setup_idx;

  lookup_if #(.SETS(SETS), .BLOCK_WORDS(BLOCK_WORDS)) lif ();
  fill_if fif ();

  // --------------------------------------------------------------------------
  // Pipeline stages
  // --------------------------------------------------------------------------
  dcache_setup #(.SETS(SETS), .BLOCK_WORDS(BLOCK_WORDS)) u_setup (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .stall_i (stall_o),
    .req_i   (mem_req_i),
    .we_i    (mem_we_i),
    .adr_i   (mem_adr_i),
    .be_i    (mem_be_i),
    .d_i     (mem_d_i),
    .req_o   (setup_req),
    .we_o    (setup_we),
    .adr_o   (setup_adr),
    .be_o    (setup_be),
    .d_o     (setup_d),
    .idx_o   (setup_idx)
  );

  dcache_lookup #(.SETS(SETS), .BLOCK_WORDS(BLOCK_WORDS)) u_lookup (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .stall_i  (stall_o),
    .req_i    (setup_req),
    .we_i     (setup_we),
    .adr_i    (setup_adr),
    .be_i     (setup_be),
    .d_i      (setup_d),
    .rd_idx_i (setup_idx),
    .lif      (lif.source),
    .fif      (fif.arr)
  );

  dcache_resp #(.BLOCK_WORDS(BLOCK_WORDS)) u_resp (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .stall_o (stall_o),
    .ack_o   (mem_ack_o),
    .err_o   (mem_err_o),
    .q_o     (mem_q_o),
    .lif     (lif.sink),
    .fif     (fif.req_mp)
  );

  dcache_biu_ctrl #(.BLOCK_WORDS(BLOCK_WORDS)) u_biu_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .biu_stb_o     (biu_stb_o),
    .biu_stb_ack_i (biu_stb_ack_i),
    .biu_adri_o    (biu_adri_o),
    .biu_we_o      (biu_we_o),
    .biu_be_o      (biu_be_o),
    .biu_d_o       (biu_d_o),
    .biu_len_o     (biu_len_o),
    .biu_q_i       (biu_q_i),
    .biu_ack_i     (biu_ack_i),
    .biu_err_i     (biu_err_i),
    .fif           (fif.bus)
  );

endmodule

`default_nettype wire

/* dv/dcache_bus_model.sv */
// Behavioral bus memory
`timescale 1ns/1ps
`default_nettype none

module dcache_bus_model #(
  parameter int               BLOCK_WORDS = 4,
  parameter dcache_pkg::adr_t POISON_BLK  = '0  // Base of the block that answers with errors
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         biu_stb_i,
  output      logic                         biu_stb_ack_o,
  input  wire dcache_pkg::adr_t             biu_adri_i,
  input  wire logic                         biu_we_i,
  input  wire dcache_pkg::be_t              biu_be_i,
  input  wire dcache_pkg::word_t            biu_d_i,
  input  wire logic [$clog2(BLOCK_WORDS):0] biu_len_i,
  output      dcache_pkg::word_t            biu_q_o,
  output      logic                         biu_ack_o,
  output      logic                         biu_err_o
);
  import dcache_pkg::*;

  localparam int BLK_LSB = $clog2(BLOCK_WORDS) + 2;

  word_t       mem [adr_t];  // Only words written by the cache
  logic [31:0] rng = 32'h5c75;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Untouched words hold their own address with a fixed upper pattern
  function automatic word_t read_word(input adr_t a);
    adr_t k;
    k = {a[PLEN-1:2], 2'b00};
    if (mem.exists(k)) return mem[k];
    return k ^ 32'hA5A5_0000;
  endfunction

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic random_wait();  // 0 to 3 cycles
    rng = xorshift(rng);
    repeat (int'(rng[1:0])) step();
  endtask

  // --------------------------------------------------------------------------
  // One bus transfer as a single write or a block burst
  // --------------------------------------------------------------------------
  task automatic serve();
    adr_t  base;
    adr_t  a;
    logic  we;
    be_t   be;
    word_t d;
    word_t w;
    int    len;
    base = biu_adri_i;
    we   = biu_we_i;
    be   = biu_be_i;
    d    = biu_d_i;
    len  = int'(biu_len_i);
    random_wait();
    biu_stb_ack_o = 1'b1;
    step();
    biu_stb_ack_o = 1'b0;
    for (int i = 0; i < len; i++) begin
      a = base + adr_t'(4 * i);
      biu_ack_o = 1'b0;
      random_wait();
      if (a[PLEN-1:BLK_LSB] == POISON_BLK[PLEN-1:BLK_LSB]) begin
        biu_err_o = 1'b1;  // Ends the transfer
        step();
        biu_err_o = 1'b0;
        break;
      end
      if (we) begin
        w = read_word(a);
        for (int b = 0; b < XLEN/8; b++) begin
          if (be[b]) w[8*b +: 8] = d[8*b +: 8];
        end
        mem[{a[PLEN-1:2], 2'b00}] = w;
      end else begin
        biu_q_o = read_word(a);
      end
      biu_ack_o = 1'b1;
      step();
    end
    biu_ack_o = 1'b0;
  endtask

  initial begin
    biu_stb_ack_o = 1'b0;
    biu_ack_o     = 1'b0;
    biu_err_o     = 1'b0;
    biu_q_o       = '0;
    forever begin
      step();
      if (rst_ni && biu_stb_i) serve();
    end
  end

endmodule

`default_nettype wire

/* dv/dcache_tb.sv */
// Data cache testbench
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
  import dcache_pkg::*;

  localparam int   BLOCK_WORDS     = 4;
  localparam int   LEN_W           = $clog2(BLOCK_WORDS) + 1;
  localparam int   N_OPS           = 12;
  localparam adr_t POISON_BLK      = 32'h0000_3010;
  localparam adr_t B2B_BASE        = 32'h0000_1000;  // Block cached at the end of the table
  localparam adr_t BLK_MASK        = adr_t'(BLOCK_WORDS * 4 - 1);
  localparam int   WATCHDOG_CYCLES = 200 * (N_OPS + 2);

  typedef enum logic [1:0] {K_HIT, K_MISS, K_WR, K_ERR} kind_e;

  typedef struct packed {
    logic  we;
    adr_t  adr;
    word_t d;
    be_t   be;
    kind_e kind;  // Expected outcome
  } op_t;

  logic             clk = 1'b0;
  logic             rst_n;
  logic             stall;
  logic             mem_req;
  logic             mem_we;
  adr_t             mem_adr;
  be_t              mem_be;
  word_t            mem_d;
  logic             mem_ack;
  logic             mem_err;
  word_t            mem_q;
  logic             biu_stb;
  logic             biu_stb_ack;
  adr_t             biu_adri;
  logic             biu_we;
  be_t              biu_be;
  word_t            biu_d;
  logic [LEN_W-1:0] biu_len;
  word_t            biu_q;
  logic             biu_ack;
  logic             biu_err;

  op_t   tbl [N_OPS];
  word_t ref_mem [adr_t];
  int    checks = 0;
  int    errors = 0;

  // Bus activity seen by the monitor
  int    bus_reqs  = 0;
  int    bus_beats = 0;
  int    acks      = 0;
  int    errs      = 0;
  adr_t  bus_adr;
  logic  bus_we;
  be_t   bus_be;
  word_t bus_d;
  int    bus_len;

  always #5 clk = ~clk;

  dcache_top #(.BLOCK_WORDS(BLOCK_WORDS)) dut0 (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .stall_o       (stall),
    .mem_req_i     (mem_req),
    .mem_we_i      (mem_we),
    .mem_adr_i     (mem_adr),
    .mem_be_i      (mem_be),
    .mem_d_i       (mem_d),
    .mem_ack_o     (mem_ack),
    .mem_err_o     (mem_err),
    .mem_q_o       (mem_q),
    .biu_stb_o     (biu_stb),
    .biu_stb_ack_i (biu_stb_ack),
    .biu_adri_o    (biu_adri),
    .biu_we_o      (biu_we),
    .biu_be_o      (biu_be),
    .biu_d_o       (biu_d),
    .biu_len_o     (biu_len),
    .biu_q_i       (biu_q),
    .biu_ack_i     (biu_ack),
    .biu_err_i     (biu_err)
  );

  dcache_bus_model #(.BLOCK_WORDS(BLOCK_WORDS), .POISON_BLK(POISON_BLK)) bus0 (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .biu_stb_i     (biu_stb),
    .biu_stb_ack_o (biu_stb_ack),
    .biu_adri_i    (biu_adri),
    .biu_we_i      (biu_we),
    .biu_be_i      (biu_be),
    .biu_d_i       (biu_d),
    .biu_len_i     (biu_len),
    .biu_q_o       (biu_q),
    .biu_ack_o     (biu_ack),
    .biu_err_o     (biu_err)
  );

  // --------------------------------------------------------------------------
  // Reference memory and checks
  // --------------------------------------------------------------------------
  function automatic word_t expected_word(input adr_t a);
    adr_t k;
    k = {a[PLEN-1:2], 2'b00};
    if (ref_mem.exists(k)) return ref_mem[k];
    return k ^ 32'hA5A5_0000;  // Initial bus memory contents
  endfunction

  task automatic merge_into_ref(input adr_t a, input word_t d, input be_t be);
    word_t w;
    w = expected_word(a);
    for (int b = 0; b < XLEN/8; b++) begin
      if (be[b]) w[8*b +: 8] = d[8*b +: 8];
    end
    ref_mem[{a[PLEN-1:2], 2'b00}] = w;
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_adr(input string name, input adr_t got, input adr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_be(input string name, input be_t got, input be_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      if (biu_stb && biu_stb_ack) begin  // Request taken by the bus
        bus_reqs++;
        bus_adr = biu_adri;
        bus_we  = biu_we;
        bus_be  = biu_be;
        bus_d   = biu_d;
        bus_len = int'(biu_len);
      end
      if (biu_ack && !biu_we) bus_beats++;
      if (mem_ack) acks++;
      if (mem_err) errs++;
    end
  end

  // --------------------------------------------------------------------------
  // CPU side sequencing
  // --------------------------------------------------------------------------
  task automatic issue_request(input op_t op);
    @(posedge clk);
    #1;
    mem_req = 1'b1;
    mem_we  = op.we;
    mem_adr = op.adr;
    mem_be  = op.be;
    mem_d   = op.d;
    do begin
      @(negedge clk);
    end while (stall);  // Taken at the next rising edge
    @(posedge clk);
    #1;
    mem_req = 1'b0;
  endtask

  task automatic wait_result(output logic ack, output logic err, output word_t q);
    ack = 1'b0;
    err = 1'b0;
    while (!ack && !err) begin
      @(negedge clk);
      ack = mem_ack;
      err = mem_err;
      q   = mem_q;
    end
  endtask

  // Until recovery is over and the monitor has settled
  task automatic wait_idle();
    do begin
      @(negedge clk);
    end while (stall);
    #1;
  endtask

  initial begin
    op_t   op;
    logic  ack;
    logic  err;
    word_t q;
    int    r0;
    int    b0;
    int    a0;
    int    e0;
    rst_n   = 1'b0;
    mem_req = 1'b0;
    mem_we  = 1'b0;
    mem_adr = '0;
    mem_be  = '0;
    mem_d   = '0;
    tbl = '{
      '{1'b0, 32'h0000_1004, 32'h0000_0000, 4'hF,    K_MISS},  // Cold miss
      '{1'b0, 32'h0000_1008, 32'h0000_0000, 4'hF,    K_HIT},
      '{1'b0, 32'h0000_100C, 32'h0000_0000, 4'hF,    K_HIT},
      '{1'b1, 32'h0000_1008, 32'hDEAD_BEEF, 4'b0011, K_WR},    // Write hit
      '{1'b0, 32'h0000_1008, 32'h0000_0000, 4'hF,    K_HIT},
      '{1'b1, 32'h0000_2044, 32'h1234_5678, 4'b1100, K_WR},    // Write miss without allocate
      '{1'b0, 32'h0000_2044, 32'h0000_0000, 4'hF,    K_MISS},
      '{1'b0, 32'h0000_1404, 32'h0000_0000, 4'hF,    K_MISS},  // Same index with other tag
      '{1'b0, 32'h0000_1004, 32'h0000_0000, 4'hF,    K_MISS},
      '{1'b0, 32'h0000_3018, 32'h0000_0000, 4'hF,    K_ERR},
      '{1'b0, 32'h0000_301C, 32'h0000_0000, 4'hF,    K_ERR},   // Block stays invalid
      '{1'b0, 32'h0000_1000, 32'h0000_0000, 4'hF,    K_HIT}
    };
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_err("stall_o", stall, 1'b0);
    check_err("mem_ack_o", mem_ack, 1'b0);
    check_err("biu_stb_o", biu_stb, 1'b0);

    for (int i = 0; i < N_OPS; i++) begin
      op = tbl[i];
      r0 = bus_reqs;
      b0 = bus_beats;
      a0 = acks;
      e0 = errs;
      issue_request(op);
      wait_result(ack, err, q);
      wait_idle();
      check_count("mem_ack_o pulses", acks - a0, (op.kind == K_ERR) ? 0 : 1);
      check_count("mem_err_o pulses", errs - e0, (op.kind == K_ERR) ? 1 : 0);
      check_count("bus requests", bus_reqs - r0, (op.kind == K_HIT) ? 0 : 1);
      if (op.kind == K_HIT || op.kind == K_MISS) begin
        check_word("mem_q_o", q, expected_word(op.adr));
      end
      if (op.kind == K_MISS || op.kind == K_ERR) begin
        check_adr("biu_adri_o", bus_adr, op.adr & ~BLK_MASK);
        check_count("biu_len_o", bus_len, BLOCK_WORDS);
        check_err("biu_we_o", bus_we, 1'b0);
      end
      if (op.kind == K_MISS) check_count("burst beats", bus_beats - b0, BLOCK_WORDS);
      if (op.kind == K_WR) begin
        check_adr("biu_adri_o", bus_adr, op.adr);
        check_word("biu_d_o", bus_d, op.d);
        check_be("biu_be_o", bus_be, op.be);
        check_err("biu_we_o", bus_we, 1'b1);
        check_count("biu_len_o", bus_len, 1);
        merge_into_ref(op.adr, op.d, op.be);
      end
    end

    // Back-to-back hits accepted one per cycle
    r0 = bus_reqs;
    for (int c = 0; c < 6; c++) begin
      @(posedge clk);
      #1;
      mem_req = (c < 4);
      mem_we  = 1'b0;
      mem_adr = B2B_BASE + adr_t'(4 * c);
      @(negedge clk);
      check_err("stall_o", stall, 1'b0);
      check_err("mem_ack_o", mem_ack, c >= 2);  // Two edges after acceptance
      if (c >= 2) check_word("mem_q_o", mem_q, expected_word(B2B_BASE + adr_t'(4 * (c - 2))));
    end
    mem_req = 1'b0;
    wait_idle();
    check_count("bus requests", bus_reqs - r0, 0);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog timeout after %0d cycles, the cache stopped answering", WATCHDOG_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
rtl/dcache_pkg.sv
rtl/dcache_if.sv
rtl/dcache_setup.sv
rtl/dcache_lookup.sv
rtl/dcache_resp.sv
rtl/dcache_biu_ctrl.sv
rtl/dcache_top.sv
dv/dcache_bus_model.sv
dv/dcache_tb.sv

/* run.sh */
#!/bin/sh
# Build the data cache testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
out="$(verilator --binary --timing -f tb.f --top-module dcache_tb -o dcache_sim 2>&1 \
  && ./obj_dir/dcache_sim 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "PASS: all tests" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
